// ==== design/fm_alg_pkg.sv ====
package fm_alg_pkg;

	// ------------------------------------------------
	// widths.
	// ------------------------------------------------
	localparam int op_w    = 14; // operator result, signed.
	localparam int mod_w   = 15; // phase modulation output, signed.
	localparam int fb_w    = 3; // feedback level.
	localparam int sum_w   = op_w + 2; // room for three summed sources.
	localparam int fb_base = 10; // feedback shift is fb_base - fb.

	// ------------------------------------------------
	// encodings.
	// ------------------------------------------------
	// hardware slot order, so a plain increment walks the sequence.
	typedef enum logic [1:0] {
		slot_s1, // first slot, carries self feedback.
		slot_s3,
		slot_s2,
		slot_s4 // last slot before wrap.
	} slot_t;

	typedef enum logic [2:0] {
		alg0, alg1, alg2, alg3,
		alg4, alg5, alg6, alg7
	} alg_t;

endpackage

// ==== design/fm_slot_if.sv ====
`timescale 1ns/1ps

// one-hot strobes naming the operator slot entering this cycle.
interface fm_slot_if;

	logic s1_enters; // slot s1 is current.
	logic s2_enters; // slot s2 is current.
	logic s3_enters; // slot s3 is current.
	logic s4_enters; // slot s4 is current.

	modport seq (
		output s1_enters, s2_enters, s3_enters, s4_enters
	);

	modport user (
		input s1_enters, s2_enters, s3_enters, s4_enters
	);

endinterface

// ==== design/fm_route_if.sv ====
`timescale 1ns/1ps

// source-select flags for the modulation summer.
interface fm_route_if;

	logic use_prevprev1; // older s1 result, or s1 via mod path.
	logic use_internal_x; // latest s1 result.
	logic use_internal_y; // latest s3 result.
	logic use_prev2; // latest s2 result.
	logic use_prev1; // result of the previous slot.

	modport route (
		output use_prevprev1, use_internal_x, use_internal_y, use_prev2, use_prev1
	);

	modport sum (
		input use_prevprev1, use_internal_x, use_internal_y, use_prev2, use_prev1
	);

endinterface

// ==== design/fm_slot_seq.sv ====
`timescale 1ns/1ps

module fm_slot_seq (
	input  logic              clk,
	input  logic              rst_n,
	fm_slot_if.seq            slot_bus,
	output fm_alg_pkg::slot_t slot
);

	// ------------------------------------------------
	// slot state stepping s1 -> s3 -> s2 -> s4 -> s1.
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot <= fm_alg_pkg::slot_s1; // restart at the feedback slot.
		end else begin
			case (slot)
				fm_alg_pkg::slot_s1: slot <= fm_alg_pkg::slot_s3;
				fm_alg_pkg::slot_s3: slot <= fm_alg_pkg::slot_s2;
				fm_alg_pkg::slot_s2: slot <= fm_alg_pkg::slot_s4;
				default:             slot <= fm_alg_pkg::slot_s1; // s4 wraps.
			endcase
		end
	end

	// strobe decode.
	assign slot_bus.s1_enters = (slot == fm_alg_pkg::slot_s1);
	assign slot_bus.s3_enters = (slot == fm_alg_pkg::slot_s3);
	assign slot_bus.s2_enters = (slot == fm_alg_pkg::slot_s2);
	assign slot_bus.s4_enters = (slot == fm_alg_pkg::slot_s4);

	// ------------------------------------------------
	// checks.
	// ------------------------------------------------
	a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot({slot_bus.s1_enters, slot_bus.s2_enters,
			slot_bus.s3_enters, slot_bus.s4_enters}))
		else $error("slot strobes not one-hot."); // memory and router rely on this.

endmodule

// ==== design/fm_mod_route.sv ====
`timescale 1ns/1ps

module fm_mod_route (
	fm_slot_if.user         slot_bus,
	input fm_alg_pkg::alg_t alg,
	fm_route_if.route       route
);

	// ------------------------------------------------
	// per-slot source decode.
	// ------------------------------------------------
	always_comb begin
		// s1 always takes its own two past outputs as feedback.
		route.use_prevprev1 = slot_bus.s1_enters ||
			(slot_bus.s3_enters && (alg == fm_alg_pkg::alg5)); // s3 fed by s1 in alg5.

		route.use_prev2 = (slot_bus.s3_enters && (alg inside {fm_alg_pkg::alg0,
			fm_alg_pkg::alg1, fm_alg_pkg::alg2})) ||
			(slot_bus.s4_enters && (alg == fm_alg_pkg::alg3)); // s2 into s4.

		route.use_internal_x = slot_bus.s4_enters &&
			(alg == fm_alg_pkg::alg2); // s1 straight into s4.

		route.use_internal_y = slot_bus.s4_enters && (alg inside {fm_alg_pkg::alg0,
			fm_alg_pkg::alg1, fm_alg_pkg::alg3, fm_alg_pkg::alg4}); // s3 into s4.

		// previous-slot chain, the serial part of each algorithm.
		route.use_prev1 = slot_bus.s1_enters ||
			(slot_bus.s3_enters && (alg == fm_alg_pkg::alg1)) ||
			(slot_bus.s2_enters && (alg inside {fm_alg_pkg::alg0, fm_alg_pkg::alg3,
				fm_alg_pkg::alg4, fm_alg_pkg::alg5, fm_alg_pkg::alg6})) ||
			(slot_bus.s4_enters && (alg inside {fm_alg_pkg::alg2,
				fm_alg_pkg::alg5}));
	end

	// alg7 sets no flag outside s1, all four carriers run unmodulated.

endmodule

// ==== design/fm_op_memory.sv ====
`timescale 1ns/1ps

module fm_op_memory (
	input  logic                                 clk,
	input  logic                                 rst_n,
	fm_slot_if.user                              slot_bus,
	input  logic signed [fm_alg_pkg::op_w-1:0]   op_result,
	output logic signed [fm_alg_pkg::op_w-1:0]   src_prev1,
	output logic signed [fm_alg_pkg::op_w-1:0]   src_prevprev1,
	output logic signed [fm_alg_pkg::op_w-1:0]   src_prev2,
	output logic signed [fm_alg_pkg::op_w-1:0]   src_internal_x,
	output logic signed [fm_alg_pkg::op_w-1:0]   src_internal_y,
	output logic                                 feedback_slot
);

	// ------------------------------------------------
	// result history.
	// ------------------------------------------------
	logic signed [fm_alg_pkg::op_w-1:0] r_prev; // last result of any slot.
	logic signed [fm_alg_pkg::op_w-1:0] r_s1_a; // newest s1 result.
	logic signed [fm_alg_pkg::op_w-1:0] r_s1_b; // s1 result one round older.
	logic signed [fm_alg_pkg::op_w-1:0] r_s2; // newest s2 result.
	logic signed [fm_alg_pkg::op_w-1:0] r_s3; // newest s3 result.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_prev <= '0; // mod starts at zero.
			r_s1_a <= '0;
			r_s1_b <= '0;
			r_s2   <= '0;
			r_s3   <= '0;
		end else begin
			r_prev <= op_result; // every slot.
			if (slot_bus.s1_enters) begin
				r_s1_b <= r_s1_a; // age the feedback pair.
				r_s1_a <= op_result;
			end
			if (slot_bus.s2_enters) begin
				r_s2 <= op_result;
			end
			if (slot_bus.s3_enters) begin
				r_s3 <= op_result;
			end
		end
	end

	// ------------------------------------------------
	// source mapping.
	// ------------------------------------------------
	// at s1 the pair is the feedback history, elsewhere it is the s1 output
	// and the slot just finished.
	assign src_prev1      = slot_bus.s1_enters ? r_s1_a : r_prev;
	assign src_prevprev1  = slot_bus.s1_enters ? r_s1_b : r_s1_a;
	assign src_prev2      = r_s2; // s2 from the last round.
	assign src_internal_x = r_s1_a;
	assign src_internal_y = r_s3;

	assign feedback_slot = slot_bus.s1_enters; // summer switches to fb scaling.

	// a stored x would spread into every later modulation value.
	a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(op_result))
		else $error("op_result unknown while being stored.");

endmodule

// ==== design/fm_mod_sum.sv ====
`timescale 1ns/1ps

module fm_mod_sum (
	fm_route_if.sum                              route,
	input  logic [fm_alg_pkg::fb_w-1:0]          fb,
	input  logic                                 feedback_slot,
	input  logic signed [fm_alg_pkg::op_w-1:0]   src_prev1,
	input  logic signed [fm_alg_pkg::op_w-1:0]   src_prevprev1,
	input  logic signed [fm_alg_pkg::op_w-1:0]   src_prev2,
	input  logic signed [fm_alg_pkg::op_w-1:0]   src_internal_x,
	input  logic signed [fm_alg_pkg::op_w-1:0]   src_internal_y,
	output logic signed [fm_alg_pkg::mod_w-1:0]  mod
);

	logic signed [fm_alg_pkg::sum_w-1:0] sum; // selected sources added.
	logic signed [fm_alg_pkg::sum_w-1:0] fb_shifted; // s1 path.
	logic signed [fm_alg_pkg::sum_w-1:0] plain_shifted; // s2..s4 path.
	logic [3:0]                          fb_shamt; // 3 to 10.

	function automatic logic signed [fm_alg_pkg::sum_w-1:0] sext(
		input logic signed [fm_alg_pkg::op_w-1:0] v
	);
		sext = {{(fm_alg_pkg::sum_w - fm_alg_pkg::op_w){v[fm_alg_pkg::op_w-1]}}, v};
	endfunction

	// ------------------------------------------------
	// sum of enabled sources.
	// ------------------------------------------------
	always_comb begin
		sum = '0;
		if (route.use_prev1)      sum = sum + sext(src_prev1);
		if (route.use_prevprev1)  sum = sum + sext(src_prevprev1);
		if (route.use_prev2)      sum = sum + sext(src_prev2);
		if (route.use_internal_x) sum = sum + sext(src_internal_x);
		if (route.use_internal_y) sum = sum + sext(src_internal_y);
	end

	// ------------------------------------------------
	// scaling.
	// ------------------------------------------------
	assign fb_shamt      = 4'(fm_alg_pkg::fb_base) - {1'b0, fb}; // higher fb, less shift.
	assign fb_shifted    = sum >>> fb_shamt;
	assign plain_shifted = sum >>> 1; // halve, three sources still fit mod_w.

	always_comb begin
		if (feedback_slot) begin
			mod = (fb == '0) ? '0 : fb_shifted[fm_alg_pkg::mod_w-1:0]; // fb 0 is off.
		end else begin
			mod = plain_shifted[fm_alg_pkg::mod_w-1:0];
		end
	end

	// three sources is the widest case sum_w is sized for. this holds only if
	// the slot strobes stay one-hot upstream.
	always_comb begin
		a_flag_count: assert ($countones({route.use_prev1, route.use_prevprev1,
			route.use_prev2, route.use_internal_x, route.use_internal_y}) <= 3)
			else $error("more than three modulation sources selected.");
	end

endmodule

// ==== design/fm_alg_top.sv ====
`timescale 1ns/1ps

module fm_alg_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  fm_alg_pkg::alg_t                     alg,
	input  logic [fm_alg_pkg::fb_w-1:0]          fb,
	input  logic signed [fm_alg_pkg::op_w-1:0]   op_result,
	output fm_alg_pkg::slot_t                    slot,
	output logic signed [fm_alg_pkg::mod_w-1:0]  mod
);

	// ------------------------------------------------
	// internal buses.
	// ------------------------------------------------
	fm_slot_if  slot_bus (); // slot strobes.
	fm_route_if route_bus (); // source selects.

	logic signed [fm_alg_pkg::op_w-1:0] src_prev1;
	logic signed [fm_alg_pkg::op_w-1:0] src_prevprev1;
	logic signed [fm_alg_pkg::op_w-1:0] src_prev2;
	logic signed [fm_alg_pkg::op_w-1:0] src_internal_x;
	logic signed [fm_alg_pkg::op_w-1:0] src_internal_y;
	logic                               feedback_slot; // s1 is current.

	fm_slot_seq u_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.slot_bus (slot_bus.seq),
		.slot     (slot)
	);

	fm_mod_route u_route (
		.slot_bus (slot_bus.user),
		.alg      (alg), // used in the cycle presented.
		.route    (route_bus.route)
	);

	fm_op_memory u_mem (
		.clk            (clk),
		.rst_n          (rst_n),
		.slot_bus       (slot_bus.user),
		.op_result      (op_result),
		.src_prev1      (src_prev1),
		.src_prevprev1  (src_prevprev1),
		.src_prev2      (src_prev2),
		.src_internal_x (src_internal_x),
		.src_internal_y (src_internal_y),
		.feedback_slot  (feedback_slot)
	);

	fm_mod_sum u_sum (
		.route          (route_bus.sum),
		.fb             (fb),
		.feedback_slot  (feedback_slot),
		.src_prev1      (src_prev1),
		.src_prevprev1  (src_prevprev1),
		.src_prev2      (src_prev2),
		.src_internal_x (src_internal_x),
		.src_internal_y (src_internal_y),
		.mod            (mod) // same cycle as slot.
	);

endmodule

// ==== tb/fm_alg_tb.sv ====
`timescale 1ns/1ps

module fm_alg_tb;

	localparam int n_rows       = 96; // 64 held-alg rows, then 32 with alg changing per slot.
	localparam int reset_cycles = 5;
	localparam int wait_limit   = 20; // cycles allowed for any wait loop.
	localparam int watchdog_ns  = 5000;

	logic                                 clk;
	logic                                 rst_n;
	fm_alg_pkg::alg_t                     alg;
	logic [fm_alg_pkg::fb_w-1:0]          fb;
	logic signed [fm_alg_pkg::op_w-1:0]   op_result;
	fm_alg_pkg::slot_t                    slot;
	logic signed [fm_alg_pkg::mod_w-1:0]  mod;

	// ------------------------------------------------
	// stimulus and expected values, one row per cycle.
	// ------------------------------------------------
	fm_alg_pkg::alg_t                    tab_alg  [n_rows];
	logic [fm_alg_pkg::fb_w-1:0]         tab_fb   [n_rows];
	logic signed [fm_alg_pkg::op_w-1:0]  tab_op   [n_rows];
	fm_alg_pkg::slot_t                   tab_slot [n_rows]; // expected.
	logic signed [fm_alg_pkg::mod_w-1:0] tab_mod  [n_rows]; // expected.

	integer seed;

	fm_alg_top fm_alg_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.alg       (alg),
		.fb        (fb),
		.op_result (op_result),
		.slot      (slot),
		.mod       (mod)
	);

	always #5 clk = ~clk; // 10 ns period.

	task automatic stop_on_failure;
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error.");
	endtask

	task automatic check_slot(input fm_alg_pkg::slot_t got, input fm_alg_pkg::slot_t exp,
		input int row);
		if (got !== exp) begin
			$display("error at %0t ns, row %0d: slot is %s (%0d), expected %s (%0d)",
				$time, row, got.name(), got, exp.name(), exp);
			stop_on_failure();
		end
	endtask

	task automatic check_mod(input logic signed [fm_alg_pkg::mod_w-1:0] got,
		input logic signed [fm_alg_pkg::mod_w-1:0] exp, input int row);
		if (got !== exp) begin
			$display("error at %0t ns, row %0d: mod is %0d, expected %0d",
				$time, row, got, exp);
			stop_on_failure();
		end
	endtask

	// ------------------------------------------------
	// reference model of routing and scaling.
	// ------------------------------------------------
	function automatic logic signed [fm_alg_pkg::mod_w-1:0] model_mod(
		input fm_alg_pkg::slot_t s, input fm_alg_pkg::alg_t a,
		input logic [fm_alg_pkg::fb_w-1:0] f,
		input int p1, input int pp1, input int p2, input int x, input int y
	);
		bit is_s1, is_s2, is_s3, is_s4;
		int sum;
		int res;
		is_s1 = (s == fm_alg_pkg::slot_s1);
		is_s2 = (s == fm_alg_pkg::slot_s2);
		is_s3 = (s == fm_alg_pkg::slot_s3);
		is_s4 = (s == fm_alg_pkg::slot_s4);
		sum = 0;
		if (is_s1 || (is_s3 && a == fm_alg_pkg::alg5)) sum += pp1;
		if ((is_s3 && a inside {fm_alg_pkg::alg0, fm_alg_pkg::alg1, fm_alg_pkg::alg2}) ||
			(is_s4 && a == fm_alg_pkg::alg3)) sum += p2;
		if (is_s4 && a == fm_alg_pkg::alg2) sum += x;
		if (is_s4 && a inside {fm_alg_pkg::alg0, fm_alg_pkg::alg1, fm_alg_pkg::alg3,
			fm_alg_pkg::alg4}) sum += y;
		if (is_s1 || (is_s3 && a == fm_alg_pkg::alg1) ||
			(is_s2 && a inside {fm_alg_pkg::alg0, fm_alg_pkg::alg3, fm_alg_pkg::alg4,
				fm_alg_pkg::alg5, fm_alg_pkg::alg6}) ||
			(is_s4 && a inside {fm_alg_pkg::alg2, fm_alg_pkg::alg5})) sum += p1;
		if (is_s1) begin
			res = (f == '0) ? 0 : (sum >>> (10 - int'(f))); // feedback scaling.
		end else begin
			res = sum >>> 1;
		end
		model_mod = res[fm_alg_pkg::mod_w-1:0];
	endfunction

	task automatic build_table;
		logic [31:0] rnd;
		int          s1_count;
		int          r;
		s1_count = 0;
		for (r = 0; r < n_rows; r++) begin
			rnd = $random(seed);
			tab_op[r] = rnd[fm_alg_pkg::op_w-1:0];
			rnd = $random(seed);
			if (r < 64) begin
				tab_alg[r] = fm_alg_pkg::alg_t'(r[5:3]); // each alg held two rounds.
				if (r[1:0] == 2'd0) begin
					tab_fb[r] = s1_count[2:0]; // walks fb 0..7 at s1.
					s1_count++;
				end else begin
					tab_fb[r] = rnd[fm_alg_pkg::fb_w-1:0];
				end
			end else begin
				tab_alg[r] = fm_alg_pkg::alg_t'(rnd[2:0]); // new alg every slot.
				tab_fb[r]  = rnd[6:4];
			end
		end
	endtask

	task automatic fill_expected;
		int                m_prev, m_s1_a, m_s1_b, m_s2, m_s3;
		int                p1, pp1;
		int                r;
		fm_alg_pkg::slot_t order [4];
		fm_alg_pkg::slot_t s;
		order[0] = fm_alg_pkg::slot_s1;
		order[1] = fm_alg_pkg::slot_s3;
		order[2] = fm_alg_pkg::slot_s2;
		order[3] = fm_alg_pkg::slot_s4;
		m_prev = 0; // reset clears history.
		m_s1_a = 0;
		m_s1_b = 0;
		m_s2   = 0;
		m_s3   = 0;
		for (r = 0; r < n_rows; r++) begin
			s = order[r[1:0]];
			p1  = (s == fm_alg_pkg::slot_s1) ? m_s1_a : m_prev;
			pp1 = (s == fm_alg_pkg::slot_s1) ? m_s1_b : m_s1_a;
			tab_slot[r] = s;
			tab_mod[r]  = model_mod(s, tab_alg[r], tab_fb[r], p1, pp1, m_s2, m_s1_a, m_s3);
			m_prev = int'(tab_op[r]); // stored at the rising edge.
			if (s == fm_alg_pkg::slot_s1) begin
				m_s1_b = m_s1_a;
				m_s1_a = int'(tab_op[r]);
			end
			if (s == fm_alg_pkg::slot_s2) m_s2 = int'(tab_op[r]);
			if (s == fm_alg_pkg::slot_s3) m_s3 = int'(tab_op[r]);
		end
	endtask

	task automatic wait_reset_slot;
		int waited;
		waited = 0;
		while (slot !== fm_alg_pkg::slot_s1) begin
			if (waited >= wait_limit) begin
				$display("reset did not bring the slot sequencer to s1 in %0d cycles.",
					wait_limit);
				stop_on_failure();
			end
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	// backstop against a stalled run.
	initial begin
		#(watchdog_ns);
		$display("simulation did not finish within %0d ns.", watchdog_ns);
		stop_on_failure();
	end

	// ------------------------------------------------
	// main sequence.
	// ------------------------------------------------
	initial begin
		int r;
		int cycles;
		clk       = 1'b0;
		rst_n     = 1'b0;
		alg       = fm_alg_pkg::alg0;
		fb        = '0;
		op_result = '0;
		seed      = 94;
		build_table();
		fill_expected();
		cycles = 0;
		while (cycles < reset_cycles) begin
			@(posedge clk);
			cycles++;
		end
		wait_reset_slot();
		for (r = 0; r < n_rows; r++) begin
			@(negedge clk);
			rst_n     = 1'b1;
			alg       = tab_alg[r];
			fb        = tab_fb[r];
			op_result = tab_op[r];
			#3; // settled, before the rising edge.
			if (r == 0) check_mod(mod, '0, r); // nothing stored yet.
			check_slot(slot, tab_slot[r], r);
			check_mod(mod, tab_mod[r], r);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
design/fm_alg_pkg.sv
design/fm_slot_if.sv
design/fm_route_if.sv
design/fm_slot_seq.sv
design/fm_mod_route.sv
design/fm_op_memory.sv
design/fm_mod_sum.sv
design/fm_alg_top.sv
tb/fm_alg_tb.sv

// ==== Makefile ====
VERILATOR = verilator
TOP = fm_alg_tb

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
